// ==== logic/bus_params.svh ====
// bus width, byte lane and memory model size macros

`ifndef BUS_PARAMS_SVH
`define BUS_PARAMS_SVH

// byte address width
`define ADDR_W 32

// data word width
`define DATA_W 32

// one write strobe per byte of the data word
`define BYTE_LANES 4

// words in the external memory model
// also bounds the random address range
`define MEM_WORDS 256

`endif

// ==== logic/bus_types_pkg.sv ====
// package of address, data word and byte enable typedefs

`include "bus_params.svh"

package bus_types_pkg;

  // byte address on every bus
  typedef logic [`ADDR_W-1:0] addr_t;

  // one data word, read or write
  typedef logic [`DATA_W-1:0] word_t;

  // write lane mask
  // bit n enables byte n of the word
  typedef logic [`BYTE_LANES-1:0] byte_en_t;

endpackage

// ==== logic/ext_bus_bridge.sv ====
// bridge that registers requests onto the external bus and returns read data

`timescale 1ns/10ps

module ext_bus_bridge (
  input  logic                    CLK,
  input  logic                    nRST,
  // granted request from the arbiter
  generic_bus_if.mem              in_bus,
  // external bus, all outputs registered
  output bus_types_pkg::addr_t    ext_addr,
  output bus_types_pkg::word_t    ext_wdata,
  output logic                    ext_ren,
  output logic                    ext_wen,
  output bus_types_pkg::byte_en_t ext_byte_en,
  input  bus_types_pkg::word_t    ext_rdata,
  input  logic                    ext_busy
);

  fsm_states_pkg::bridge_state_t state;

  // read data captured on the completing external edge
  bus_types_pkg::word_t rdata_q;

  // new request seen while idle
  logic start;

  assign start = (state == fsm_states_pkg::BRIDGE_IDLE) & (in_bus.ren | in_bus.wen);

  // control path
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state   <= fsm_states_pkg::BRIDGE_IDLE;
      ext_ren <= 1'b0;
      ext_wen <= 1'b0;
    end else begin
      case (state)
        fsm_states_pkg::BRIDGE_IDLE: begin
          if (start) begin
            ext_ren <= in_bus.ren;
            ext_wen <= in_bus.wen;
            state   <= fsm_states_pkg::BRIDGE_ACCESS;
          end
        end
        // hold the request through wait states
        fsm_states_pkg::BRIDGE_ACCESS: begin
          if (!ext_busy) begin
            ext_ren <= 1'b0;
            ext_wen <= 1'b0;
            state   <= fsm_states_pkg::BRIDGE_RESPOND;
          end
        end
        // one completion cycle toward the arbiter
        fsm_states_pkg::BRIDGE_RESPOND: begin
          state <= fsm_states_pkg::BRIDGE_IDLE;
        end
        default: begin
          state <= fsm_states_pkg::BRIDGE_IDLE;
        end
      endcase
    end
  end

  // payload path
  // address and write fields only load at start
  always_ff @(posedge CLK) begin
    if (start) begin
      ext_addr    <= in_bus.addr;
      ext_wdata   <= in_bus.wdata;
      ext_byte_en <= in_bus.byte_en;
    end
    if ((state == fsm_states_pkg::BRIDGE_ACCESS) && !ext_busy) begin
      rdata_q <= ext_rdata;
    end
  end

  // busy low only in the respond cycle
  assign in_bus.busy  = (state != fsm_states_pkg::BRIDGE_RESPOND);
  assign in_bus.rdata = rdata_q;

endmodule

// ==== logic/fsm_states_pkg.sv ====
// package of arbiter and bridge state enums

package fsm_states_pkg;

  // arbiter grant state
  // a grant holds until its transfer completes
  typedef enum logic [1:0] {
    ARB_IDLE    = 2'b00,
    ARB_SERVE_I = 2'b01,
    ARB_SERVE_D = 2'b10
  } arb_state_t;

  // bridge transfer state
  typedef enum logic [1:0] {
    BRIDGE_IDLE    = 2'b00,
    BRIDGE_ACCESS  = 2'b01,
    BRIDGE_RESPOND = 2'b10
  } bridge_state_t;

endpackage

// ==== logic/generic_bus_if.sv ====
// request/busy bus interface with cpu and mem modports

`timescale 1ns/10ps

interface generic_bus_if;

  // request side
  bus_types_pkg::addr_t    addr;
  bus_types_pkg::word_t    wdata;
  logic                    ren;
  logic                    wen;
  bus_types_pkg::byte_en_t byte_en;

  // response side
  // busy stays high until the completing cycle
  bus_types_pkg::word_t    rdata;
  logic                    busy;

  // requester view
  modport cpu (
    output addr, wdata, ren, wen, byte_en,
    input  rdata, busy
  );

  // responder view
  modport mem (
    input  addr, wdata, ren, wen, byte_en,
    output rdata, busy
  );

endinterface

// ==== logic/mem_arbiter.sv ====
// arbiter granting the instruction or data port to the shared bus

`timescale 1ns/10ps

module mem_arbiter (
  input  logic                    CLK,
  input  logic                    nRST,
  // instruction fetch port, reads only
  input  bus_types_pkg::addr_t    i_addr,
  input  logic                    i_ren,
  output bus_types_pkg::word_t    i_rdata,
  output logic                    i_busy,
  // data port
  input  bus_types_pkg::addr_t    d_addr,
  input  bus_types_pkg::word_t    d_wdata,
  input  logic                    d_ren,
  input  logic                    d_wen,
  input  bus_types_pkg::byte_en_t d_byte_en,
  output bus_types_pkg::word_t    d_rdata,
  output logic                    d_busy,
  // shared bus toward the bridge
  generic_bus_if.cpu              out_bus
);

  fsm_states_pkg::arb_state_t state;
  fsm_states_pkg::arb_state_t next_state;

  // data side asks for either direction
  logic d_req;
  // current owner of out_bus
  logic grant_i;
  logic grant_d;

  assign d_req = d_ren | d_wen;

  // grant decode
  // from idle the choice is made in the same cycle with data first
  always_comb begin
    grant_i = 1'b0;
    grant_d = 1'b0;
    case (state)
      fsm_states_pkg::ARB_IDLE: begin
        grant_d = d_req;
        grant_i = ~d_req & i_ren;
      end
      fsm_states_pkg::ARB_SERVE_I: begin
        grant_i = 1'b1;
      end
      fsm_states_pkg::ARB_SERVE_D: begin
        grant_d = 1'b1;
      end
      default: begin
        grant_i = 1'b0;
      end
    endcase
  end

  // next state
  always_comb begin
    next_state = state;
    case (state)
      fsm_states_pkg::ARB_IDLE: begin
        if (grant_d) begin
          next_state = fsm_states_pkg::ARB_SERVE_D;
        end else if (grant_i) begin
          next_state = fsm_states_pkg::ARB_SERVE_I;
        end
      end
      // release after the completing low-busy cycle
      fsm_states_pkg::ARB_SERVE_I, fsm_states_pkg::ARB_SERVE_D: begin
        if (!out_bus.busy) begin
          next_state = fsm_states_pkg::ARB_IDLE;
        end
      end
      default: begin
        next_state = fsm_states_pkg::ARB_IDLE;
      end
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= fsm_states_pkg::ARB_IDLE;
    end else begin
      state <= next_state;
    end
  end

  // request mux onto the shared bus
  // fetch never writes, so its write fields are held inactive
  assign out_bus.addr    = grant_d ? d_addr : i_addr;
  assign out_bus.wdata   = grant_d ? d_wdata : '0;
  assign out_bus.byte_en = grant_d ? d_byte_en : '0;
  assign out_bus.ren     = grant_d ? d_ren : (grant_i & i_ren);
  assign out_bus.wen     = grant_d & d_wen;

  // read data goes to both ports
  // only the owner sees busy drop
  assign i_rdata = out_bus.rdata;
  assign d_rdata = out_bus.rdata;
  assign i_busy  = grant_i ? out_bus.busy : 1'b1;
  assign d_busy  = grant_d ? out_bus.busy : 1'b1;

endmodule

// ==== logic/mem_subsystem.sv ====
// top level joining the arbiter and the external bus bridge

`timescale 1ns/10ps

module mem_subsystem (
  input  logic                    CLK,
  input  logic                    nRST,
  // instruction fetch port
  input  bus_types_pkg::addr_t    i_addr,
  input  logic                    i_ren,
  output bus_types_pkg::word_t    i_rdata,
  output logic                    i_busy,
  // data port
  input  bus_types_pkg::addr_t    d_addr,
  input  bus_types_pkg::word_t    d_wdata,
  input  logic                    d_ren,
  input  logic                    d_wen,
  input  bus_types_pkg::byte_en_t d_byte_en,
  output bus_types_pkg::word_t    d_rdata,
  output logic                    d_busy,
  // external memory bus
  output bus_types_pkg::addr_t    ext_addr,
  output bus_types_pkg::word_t    ext_wdata,
  output logic                    ext_ren,
  output logic                    ext_wen,
  output bus_types_pkg::byte_en_t ext_byte_en,
  input  bus_types_pkg::word_t    ext_rdata,
  input  logic                    ext_busy
);

  // arbiter to bridge
  generic_bus_if arb_bus ();

  // memory controller role
  mem_arbiter arbiter_inst (
    .CLK       (CLK),
    .nRST      (nRST),
    .i_addr    (i_addr),
    .i_ren     (i_ren),
    .i_rdata   (i_rdata),
    .i_busy    (i_busy),
    .d_addr    (d_addr),
    .d_wdata   (d_wdata),
    .d_ren     (d_ren),
    .d_wen     (d_wen),
    .d_byte_en (d_byte_en),
    .d_rdata   (d_rdata),
    .d_busy    (d_busy),
    .out_bus   (arb_bus)
  );

  // bus translator role, non-pipelined
  ext_bus_bridge bridge_inst (
    .CLK         (CLK),
    .nRST        (nRST),
    .in_bus      (arb_bus),
    .ext_addr    (ext_addr),
    .ext_wdata   (ext_wdata),
    .ext_ren     (ext_ren),
    .ext_wen     (ext_wen),
    .ext_byte_en (ext_byte_en),
    .ext_rdata   (ext_rdata),
    .ext_busy    (ext_busy)
  );

endmodule

// ==== run_sim.sh ====
#!/bin/bash
# build and run the mem_subsystem testbench with Verilator
# exit status is 0 only when the pass line shows up

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f tb.f --top-module mem_subsystem_tb -Mdir obj_dir \
  || { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/Vmem_subsystem_tb)
echo "$sim_out"
echo "$sim_out" | grep -qxF "All tests passed!" && exit 0 || exit 1

// ==== tb.f ====
+incdir+logic
logic/bus_types_pkg.sv
logic/fsm_states_pkg.sv
logic/generic_bus_if.sv
logic/mem_arbiter.sv
logic/ext_bus_bridge.sv
logic/mem_subsystem.sv
verif/mem_subsystem_properties.sv
verif/mem_subsystem_tb.sv

// ==== verif/mem_subsystem_properties.sv ====
// concurrent assertions on the external bus and port busy outputs, and their bind

`timescale 1ns/10ps

module mem_subsystem_properties (
  input logic                    CLK,
  input logic                    nRST,
  input bus_types_pkg::addr_t    ext_addr,
  input bus_types_pkg::word_t    ext_wdata,
  input logic                    ext_ren,
  input logic                    ext_wen,
  input bus_types_pkg::byte_en_t ext_byte_en,
  input logic                    ext_busy,
  input logic                    i_busy,
  input logic                    d_busy
);

  // one direction per external request
  ext_one_direction: assert property (@(posedge CLK) disable iff (!nRST)
    !(ext_ren && ext_wen))
    else $error("ext_ren and ext_wen high together");

  // payload frozen through wait states
  ext_request_stable: assert property (@(posedge CLK) disable iff (!nRST)
    (ext_ren || ext_wen) && ext_busy |=>
      $stable(ext_addr) && $stable(ext_wdata) && $stable(ext_byte_en))
    else $error("external request changed while ext_busy was high");

  // a single completion per cycle
  one_port_done: assert property (@(posedge CLK) disable iff (!nRST)
    !(!i_busy && !d_busy))
    else $error("i_busy and d_busy low in the same cycle");

endmodule

bind mem_subsystem mem_subsystem_properties properties_inst (
  .CLK         (CLK),
  .nRST        (nRST),
  .ext_addr    (ext_addr),
  .ext_wdata   (ext_wdata),
  .ext_ren     (ext_ren),
  .ext_wen     (ext_wen),
  .ext_byte_en (ext_byte_en),
  .ext_busy    (ext_busy),
  .i_busy      (i_busy),
  .d_busy      (d_busy)
);

// ==== verif/mem_subsystem_tb.sv ====
// testbench with clock, reset, LFSR, memory and shadow models, stimulus and checks

`timescale 1ns/10ps

`include "bus_params.svh"

module mem_subsystem_tb;

  localparam int IDX_W      = $clog2(`MEM_WORDS);
  // data has priority, so fetch can wait through long runs of data traffic
  localparam int WAIT_LIMIT = 512;

  logic                    CLK = 1'b0;
  logic                    nRST;
  bus_types_pkg::addr_t    i_addr;
  logic                    i_ren;
  bus_types_pkg::word_t    i_rdata;
  logic                    i_busy;
  bus_types_pkg::addr_t    d_addr;
  bus_types_pkg::word_t    d_wdata;
  logic                    d_ren;
  logic                    d_wen;
  bus_types_pkg::byte_en_t d_byte_en;
  bus_types_pkg::word_t    d_rdata;
  logic                    d_busy;
  bus_types_pkg::addr_t    ext_addr;
  bus_types_pkg::word_t    ext_wdata;
  logic                    ext_ren;
  logic                    ext_wen;
  bus_types_pkg::byte_en_t ext_byte_en;
  bus_types_pkg::word_t    ext_rdata;
  logic                    ext_busy;

  // external memory and the expected image of it
  bus_types_pkg::word_t ext_mem [`MEM_WORDS];
  bus_types_pkg::word_t shadow  [`MEM_WORDS];

  // separate streams for stimulus and wait states
  logic [31:0] stim_lfsr;
  logic [31:0] wait_lfsr;
  int          errors;
  int          checks;
  int          test_start;
  bit          timed_out;

  mem_subsystem mem_subsystem_inst (.*);

  always #4 CLK = ~CLK;

  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one LFSR step per bit taken
  task automatic draw_bits(input int n, inout logic [31:0] state, output logic [31:0] value);
    int k;
    value = '0;
    for (k = 0; k < n; k++) begin
      state = lfsr_next(state);
      value = {value[30:0], state[0]};
    end
  endtask

  // odd multiplier so every index bit reaches the word
  function automatic bus_types_pkg::word_t fill_word(input int k);
    return 32'hc001_0000 ^ (k * 32'h9e37_79b1);
  endfunction

  // enabled lanes take the new byte
  function automatic bus_types_pkg::word_t merge_bytes(input bus_types_pkg::word_t old_word,
      input bus_types_pkg::word_t new_word, input bus_types_pkg::byte_en_t be);
    bus_types_pkg::word_t result;
    int b;
    result = old_word;
    for (b = 0; b < `BYTE_LANES; b++) begin
      if (be[b]) result[8*b +: 8] = new_word[8*b +: 8];
    end
    return result;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  // inputs change 1 ns after the rising edge
  task automatic next_drive_point();
    @(posedge CLK);
    #1;
  endtask

  // word aligned address inside the model
  task automatic rand_addr(output bus_types_pkg::addr_t addr);
    logic [31:0] v;
    draw_bits(IDX_W, stim_lfsr, v);
    addr = '0;
    addr[IDX_W+1:2] = v[IDX_W-1:0];
  endtask

  // poll the port's busy at each falling edge
  task automatic wait_busy_low(input bit data_port);
    int cycles;
    cycles = 0;
    @(negedge CLK);
    while ((data_port ? d_busy : i_busy) && !timed_out) begin
      if (cycles == WAIT_LIMIT) begin
        $display("timeout: %s port request still busy after %0d cycles",
                 data_port ? "data" : "fetch", WAIT_LIMIT);
        timed_out = 1'b1;
      end else begin
        @(negedge CLK);
        cycles++;
      end
    end
  endtask

  task automatic fetch_read(input bus_types_pkg::addr_t addr);
    i_addr = addr;
    i_ren  = 1'b1;
    wait_busy_low(1'b0);
    if (!timed_out) check_value("i_rdata", shadow[addr[IDX_W+1:2]], i_rdata);
    next_drive_point();
    i_ren = 1'b0;
  endtask

  task automatic data_write(input bus_types_pkg::addr_t addr, input bus_types_pkg::word_t wdata,
                            input bus_types_pkg::byte_en_t be);
    d_addr    = addr;
    d_wdata   = wdata;
    d_byte_en = be;
    d_ren     = 1'b0;
    d_wen     = 1'b1;
    wait_busy_low(1'b1);
    // shadow follows the completed store
    if (!timed_out) begin
      shadow[addr[IDX_W+1:2]] = merge_bytes(shadow[addr[IDX_W+1:2]], wdata, be);
    end
    next_drive_point();
    d_wen = 1'b0;
  endtask

  task automatic data_read(input bus_types_pkg::addr_t addr);
    d_addr = addr;
    d_wen  = 1'b0;
    d_ren  = 1'b1;
    wait_busy_low(1'b1);
    if (!timed_out) check_value("d_rdata", shadow[addr[IDX_W+1:2]], d_rdata);
    next_drive_point();
    d_ren = 1'b0;
  endtask

  // first request to leave the bridge
  task automatic first_ext_addr(input bus_types_pkg::addr_t expected);
    int cycles;
    cycles = 0;
    @(negedge CLK);
    while (!(ext_ren || ext_wen) && cycles < WAIT_LIMIT) begin
      @(negedge CLK);
      cycles++;
    end
    if (ext_ren || ext_wen) begin
      check_value("ext_addr", expected, ext_addr);
    end else begin
      $display("timeout: no external request after the simultaneous start");
      timed_out = 1'b1;
    end
  endtask

  task automatic simultaneous_start();
    bus_types_pkg::addr_t ia;
    bus_types_pkg::addr_t da;
    rand_addr(ia);
    rand_addr(da);
    // distinct addresses so the winner shows on ext_addr
    if (da == ia) da[2] = ~da[2];
    fork
      fetch_read(ia);
      data_read(da);
      first_ext_addr(da);
    join
  endtask

  task automatic fetch_traffic(input int n);
    bus_types_pkg::addr_t addr;
    logic [31:0] gap;
    int k;
    for (k = 0; k < n; k++) begin
      draw_bits(2, stim_lfsr, gap);
      if (gap == 0) next_drive_point();
      rand_addr(addr);
      fetch_read(addr);
    end
  endtask

  // loads and stores mixed evenly
  task automatic data_traffic(input int n);
    bus_types_pkg::addr_t addr;
    logic [31:0] op;
    logic [31:0] wdata;
    logic [31:0] be;
    int k;
    for (k = 0; k < n; k++) begin
      draw_bits(2, stim_lfsr, op);
      if (op == 0) next_drive_point();
      rand_addr(addr);
      draw_bits(1, stim_lfsr, op);
      if (op[0]) begin
        draw_bits(32, stim_lfsr, wdata);
        draw_bits(`BYTE_LANES, stim_lfsr, be);
        data_write(addr, wdata, be[`BYTE_LANES-1:0]);
      end else begin
        data_read(addr);
      end
    end
  endtask

  task automatic end_test(input int num, input string name);
    string verdict;
    if (errors == test_start && !timed_out) begin
      verdict = "ok";
    end else begin
      verdict = "failed";
    end
    $display("test %0d %s: %s, %0d errors", num, name, verdict, errors - test_start);
    test_start = errors;
  endtask

  // external memory with 0 to 3 wait cycles per access
  initial begin
    int k;
    bit in_access;
    int wait_left;
    logic [31:0] wait_draw;
    ext_busy  = 1'b1;
    ext_rdata = '0;
    in_access = 1'b0;
    wait_left = 0;
    wait_lfsr = 32'h7d704a27;
    for (k = 0; k < `MEM_WORDS; k++) ext_mem[k] = fill_word(k);
    forever begin
      @(posedge CLK);
      #1;
      if (!nRST) begin
        ext_busy  = 1'b1;
        in_access = 1'b0;
      end else if (!ext_busy) begin
        // completion taken on the last edge
        ext_busy = 1'b1;
      end else if (ext_ren || ext_wen) begin
        if (!in_access) begin
          in_access = 1'b1;
          draw_bits(2, wait_lfsr, wait_draw);
          wait_left = int'(wait_draw);
        end
        if (wait_left == 0) begin
          if (ext_wen) begin
            ext_mem[ext_addr[IDX_W+1:2]] =
              merge_bytes(ext_mem[ext_addr[IDX_W+1:2]], ext_wdata, ext_byte_en);
          end
          ext_rdata = ext_mem[ext_addr[IDX_W+1:2]];
          ext_busy  = 1'b0;
          in_access = 1'b0;
        end else begin
          wait_left--;
        end
      end
    end
  end

  initial begin
    int k;
    logic [31:0] wdata;
    logic [31:0] be;
    bus_types_pkg::addr_t addr;
    bus_types_pkg::addr_t wr_addr [16];
    nRST      = 1'b0;
    i_addr    = '0;
    i_ren     = 1'b0;
    d_addr    = '0;
    d_wdata   = '0;
    d_ren     = 1'b0;
    d_wen     = 1'b0;
    d_byte_en = '0;
    stim_lfsr = 32'h7d704a27;
    errors     = 0;
    checks     = 0;
    test_start = 0;
    timed_out  = 1'b0;
    for (k = 0; k < `MEM_WORDS; k++) shadow[k] = fill_word(k);

    // reset state inside reset and just after it
    @(negedge CLK);
    check_value("ext_ren", 32'd0, 32'(ext_ren));
    check_value("ext_wen", 32'd0, 32'(ext_wen));
    check_value("i_busy", 32'd1, 32'(i_busy));
    check_value("d_busy", 32'd1, 32'(d_busy));
    repeat (4) @(posedge CLK);
    #1;
    nRST = 1'b1;
    @(negedge CLK);
    check_value("ext_ren", 32'd0, 32'(ext_ren));
    check_value("ext_wen", 32'd0, 32'(ext_wen));
    check_value("i_busy", 32'd1, 32'(i_busy));
    check_value("d_busy", 32'd1, 32'(d_busy));
    next_drive_point();
    end_test(1, "reset state");

    for (k = 0; k < 40; k++) begin
      rand_addr(addr);
      fetch_read(addr);
    end
    end_test(2, "fetch reads");

    // stores first, then read back the same words
    for (k = 0; k < 16; k++) begin
      rand_addr(wr_addr[k]);
      draw_bits(32, stim_lfsr, wdata);
      draw_bits(`BYTE_LANES, stim_lfsr, be);
      data_write(wr_addr[k], wdata, be[`BYTE_LANES-1:0]);
    end
    for (k = 0; k < 16; k++) data_read(wr_addr[k]);
    end_test(3, "byte enable writes");

    for (k = 0; k < 8; k++) begin
      simultaneous_start();
      next_drive_point();
    end
    end_test(4, "simultaneous start");

    fork
      fetch_traffic(200);
      data_traffic(200);
    join
    end_test(5, "random traffic");

    $display("checks: %0d, errors: %0d, timeout: %0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
